/* hdl/decode_pkg.sv */
package decode_pkg;

    localparam int PC_WIDTH       = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int ECAUSE_WIDTH   = 5;
    localparam int INST_WIDTH     = 32;

    // top bit of the cause marks an interrupt
    localparam logic [ECAUSE_WIDTH-1:0] CAUSE_IRQ_FLAG = 5'b1_0000;

    localparam logic [ECAUSE_WIDTH-1:0] CAUSE_ILLEGAL_INST = 5'd2;
    localparam logic [ECAUSE_WIDTH-1:0] CAUSE_IRQ_EXTERNAL = CAUSE_IRQ_FLAG | 5'd9;
    localparam logic [ECAUSE_WIDTH-1:0] CAUSE_IRQ_S_TIMER  = CAUSE_IRQ_FLAG | 5'd5;
    localparam logic [ECAUSE_WIDTH-1:0] CAUSE_IRQ_M_TIMER  = CAUSE_IRQ_FLAG | 5'd7;
    localparam logic [ECAUSE_WIDTH-1:0] CAUSE_IRQ_S_SOFT   = CAUSE_IRQ_FLAG | 5'd1;
    localparam logic [ECAUSE_WIDTH-1:0] CAUSE_IRQ_M_SOFT   = CAUSE_IRQ_FLAG | 5'd3;

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // operand selects
    localparam logic [1:0] SEL_A_REG  = 2'd0;
    localparam logic [1:0] SEL_A_PC   = 2'd1;
    localparam logic [1:0] SEL_A_ZERO = 2'd2;
    localparam logic [1:0] SEL_B_REG  = 2'd0;
    localparam logic [1:0] SEL_B_IMM  = 2'd1;
    localparam logic [1:0] SEL_B_FOUR = 2'd2;

    localparam int DEC_QUEUE_DEPTH     = 8; // power of two, pointers wrap
    localparam int DEC_QUEUE_PTR_WIDTH = $clog2(DEC_QUEUE_DEPTH);

    typedef struct packed {
        logic [PC_WIDTH-1:0]     pc;
        logic [PC_WIDTH-1:0]     next_pc;
        logic [PC_WIDTH-1:0]     predicted_pc;
        logic [INST_WIDTH-1:0]   instruction;
        logic                    exception;
        logic [ECAUSE_WIDTH-1:0] ecause;
    } fetch_slot_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0]       pc;
        logic [PC_WIDTH-1:0]       next_pc;
        logic [PC_WIDTH-1:0]       predicted_pc;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic                      uses_rs1;
        logic                      uses_rs2;
        logic                      uses_rd;
        logic [31:0]               imm;
        logic [2:0]                fu_function;  // funct3
        logic                      alu_modifier; // inst bit 30
        logic [1:0]                select_a;
        logic [1:0]                select_b;
        logic                      is_alu;
        logic                      load;
        logic                      store;
        logic                      branch;
        logic                      jump;
        logic                      exception;
        logic [ECAUSE_WIDTH-1:0]   ecause;
    } dec_entry_t;

endpackage

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::fetch_slot_t slot_i,
    output decode_pkg::dec_entry_t  entry_o
);

    logic [31:0] inst;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        illegal;
    decode_pkg::dec_entry_t dec;

    assign inst   = slot_i.instruction;
    assign opcode = inst[6:0]; // low bits not 11 never match an opcode below
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec              = '0;
        illegal          = 1'b0;
        dec.pc           = slot_i.pc;
        dec.next_pc      = slot_i.next_pc;
        dec.predicted_pc = slot_i.predicted_pc;
        dec.rs1          = inst[19:15];
        dec.rs2          = inst[24:20];
        dec.rd           = inst[11:7];
        dec.fu_function  = funct3;
        case (opcode)
            decode_pkg::OPC_LUI: begin
                dec.uses_rd     = 1'b1;
                dec.imm         = imm_u;
                dec.fu_function = 3'b000; // zero + imm
                dec.select_a    = decode_pkg::SEL_A_ZERO;
                dec.select_b    = decode_pkg::SEL_B_IMM;
                dec.is_alu      = 1'b1;
            end
            decode_pkg::OPC_AUIPC: begin
                dec.uses_rd     = 1'b1;
                dec.imm         = imm_u;
                dec.fu_function = 3'b000;
                dec.select_a    = decode_pkg::SEL_A_PC;
                dec.select_b    = decode_pkg::SEL_B_IMM;
                dec.is_alu      = 1'b1;
            end
            decode_pkg::OPC_JAL: begin
                dec.uses_rd     = 1'b1;
                dec.imm         = imm_j;
                dec.fu_function = 3'b000; // funct3 bits belong to the offset
                dec.select_a    = decode_pkg::SEL_A_PC;
                dec.select_b    = decode_pkg::SEL_B_FOUR;
                dec.jump        = 1'b1;
            end
            decode_pkg::OPC_JALR: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rd  = 1'b1;
                dec.imm      = imm_i;
                dec.select_a = decode_pkg::SEL_A_PC;
                dec.select_b = decode_pkg::SEL_B_FOUR;
                dec.jump     = 1'b1;
                illegal      = (funct3 != 3'b000);
            end
            decode_pkg::OPC_BRANCH: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.imm      = imm_b;
                dec.select_a = decode_pkg::SEL_A_REG;
                dec.select_b = decode_pkg::SEL_B_REG;
                dec.branch   = 1'b1;
                illegal      = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            decode_pkg::OPC_LOAD: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rd  = 1'b1;
                dec.imm      = imm_i;
                dec.select_a = decode_pkg::SEL_A_REG;
                dec.select_b = decode_pkg::SEL_B_IMM;
                dec.load     = 1'b1;
                illegal      = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
            end
            decode_pkg::OPC_STORE: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.imm      = imm_s;
                dec.select_a = decode_pkg::SEL_A_REG;
                dec.select_b = decode_pkg::SEL_B_IMM;
                dec.store    = 1'b1;
                illegal      = (funct3 > 3'b010);
            end
            decode_pkg::OPC_OP_IMM: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rd  = 1'b1;
                dec.imm      = imm_i;
                dec.select_a = decode_pkg::SEL_A_REG;
                dec.select_b = decode_pkg::SEL_B_IMM;
                dec.is_alu   = 1'b1;
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000); // slli
                end else if (funct3 == 3'b101) begin
                    dec.alu_modifier = inst[30]; // srli / srai
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            decode_pkg::OPC_OP: begin
                dec.uses_rs1     = 1'b1;
                dec.uses_rs2     = 1'b1;
                dec.uses_rd      = 1'b1;
                dec.select_a     = decode_pkg::SEL_A_REG;
                dec.select_b     = decode_pkg::SEL_B_REG;
                dec.is_alu       = 1'b1;
                dec.alu_modifier = inst[30];
                // sub and sra are the only alternate encodings
                if (funct7 == 7'b0100000) begin
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    illegal = (funct7 != 7'b0000000);
                end
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        entry_o = dec;
        if (slot_i.exception || illegal) begin
            entry_o.uses_rs1     = 1'b0;
            entry_o.uses_rs2     = 1'b0;
            entry_o.uses_rd      = 1'b0;
            entry_o.fu_function  = 3'b000;
            entry_o.alu_modifier = 1'b0;
            entry_o.select_a     = decode_pkg::SEL_A_REG;
            entry_o.select_b     = decode_pkg::SEL_B_REG;
            entry_o.is_alu       = 1'b0;
            entry_o.load         = 1'b0;
            entry_o.store        = 1'b0;
            entry_o.branch       = 1'b0;
            entry_o.jump         = 1'b0;
            entry_o.exception    = 1'b1;
            // fetch fault wins over a bad encoding
            entry_o.ecause = slot_i.exception ? slot_i.ecause : decode_pkg::CAUSE_ILLEGAL_INST;
        end
    end

    always_comb begin
        assert (!(entry_o.exception && (entry_o.load || entry_o.store)))
            else $error("faulting entry still requests a memory access");
    end

endmodule

/* hdl/irq_override.sv */
`timescale 1ns/1ps

module irq_override (
    input  decode_pkg::dec_entry_t entry_first_i,
    input  decode_pkg::dec_entry_t entry_second_i,
    input  logic                   eip_i,
    input  logic                   stip_i,
    input  logic                   mtip_i,
    input  logic                   ssip_i,
    input  logic                   msip_i,
    output decode_pkg::dec_entry_t entry_first_o,
    output decode_pkg::dec_entry_t entry_second_o
);

    logic                                irq_pending;
    logic [decode_pkg::ECAUSE_WIDTH-1:0] irq_cause;

    assign irq_pending = eip_i | stip_i | mtip_i | ssip_i | msip_i;

    // fixed priority, external first
    always_comb begin
        if (eip_i) begin
            irq_cause = decode_pkg::CAUSE_IRQ_EXTERNAL;
        end else if (stip_i) begin
            irq_cause = decode_pkg::CAUSE_IRQ_S_TIMER;
        end else if (mtip_i) begin
            irq_cause = decode_pkg::CAUSE_IRQ_M_TIMER;
        end else if (ssip_i) begin
            irq_cause = decode_pkg::CAUSE_IRQ_S_SOFT;
        end else begin
            irq_cause = decode_pkg::CAUSE_IRQ_M_SOFT; // only used with msip
        end
    end

    always_comb begin
        entry_first_o  = entry_first_i;
        entry_second_o = entry_second_i;
        if (irq_pending) begin
            entry_first_o.exception  = 1'b1;
            entry_first_o.ecause     = irq_cause;
            entry_second_o.exception = 1'b1;
            entry_second_o.ecause    = irq_cause;
        end
    end

endmodule

/* hdl/dual_queue.sv */
`timescale 1ns/1ps

module dual_queue #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   flush_i,
    input  logic   wr_valid_first_i,
    input  logic   wr_valid_second_i,
    input  logic   rd_ready_first_i,
    input  logic   rd_ready_second_i,
    input  entry_t wdata_first_i,
    input  entry_t wdata_second_i,
    output entry_t rdata_first_o,
    output entry_t rdata_second_o,
    output logic   rd_valid_first_o,
    output logic   rd_valid_second_o,
    output logic   single_space_o,
    output logic   double_space_o
);

    typedef logic [decode_pkg::DEC_QUEUE_PTR_WIDTH-1:0] ptr_t;
    typedef logic [decode_pkg::DEC_QUEUE_PTR_WIDTH:0]   cnt_t;

    entry_t mem [decode_pkg::DEC_QUEUE_DEPTH];

    ptr_t head_q;
    ptr_t tail_q;
    ptr_t head_next;
    ptr_t tail_next;
    cnt_t count_q;

    logic full;
    logic almost_full;
    logic empty;
    logic almost_empty;
    logic wr_first_en;
    logic wr_second_en;
    logic rd_first_en;
    logic rd_second_en;

    assign full         = (count_q == cnt_t'(decode_pkg::DEC_QUEUE_DEPTH));
    assign almost_full  = (count_q >= cnt_t'(decode_pkg::DEC_QUEUE_DEPTH - 1));
    assign empty        = (count_q == '0);
    assign almost_empty = (count_q <= cnt_t'(1)); // fewer than two

    // a lone valid always lands on the first port
    assign wr_first_en  = (wr_valid_first_i | wr_valid_second_i) & ~full;
    assign wr_second_en = wr_valid_first_i & wr_valid_second_i & ~almost_full;
    assign rd_first_en  = (rd_ready_first_i | rd_ready_second_i) & ~empty;
    assign rd_second_en = rd_ready_first_i & rd_ready_second_i & ~almost_empty;

    assign head_next = head_q + ptr_t'(1);
    assign tail_next = tail_q + ptr_t'(1);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + ptr_t'(rd_first_en) + ptr_t'(rd_second_en);
            tail_q  <= tail_q + ptr_t'(wr_first_en) + ptr_t'(wr_second_en);
            count_q <= count_q + cnt_t'(wr_first_en) + cnt_t'(wr_second_en)
                     - cnt_t'(rd_first_en) - cnt_t'(rd_second_en);
        end
    end

    always_ff @(posedge clk) begin
        if (!flush_i) begin
            if (wr_first_en) begin
                mem[tail_q] <= wdata_first_i;
            end
            if (wr_second_en) begin
                mem[tail_next] <= wdata_second_i;
            end
        end
    end

    assign rdata_first_o  = mem[head_q];
    assign rdata_second_o = mem[head_next];

    assign rd_valid_first_o  = ~empty;
    assign rd_valid_second_o = ~almost_empty;
    assign single_space_o    = ~full;
    assign double_space_o    = ~almost_full;

    count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        count_q <= cnt_t'(decode_pkg::DEC_QUEUE_DEPTH));

    // a full queue takes nothing, so the tail holds
    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        full && !flush_i |=> tail_q == $past(tail_q));

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // fetch
    input  decode_pkg::fetch_slot_t fetch_slot_first_i,
    input  decode_pkg::fetch_slot_t fetch_slot_second_i,
    input  logic                    fetch_valid_first_i,
    input  logic                    fetch_valid_second_i,
    output logic                    fetch_single_ready_o,
    output logic                    fetch_double_ready_o,

    // rob
    input  logic                    rob_ready_first_i,
    input  logic                    rob_ready_second_i,
    output decode_pkg::dec_entry_t  entry_first_o,
    output decode_pkg::dec_entry_t  entry_second_o,
    output logic                    rob_valid_first_o,
    output logic                    rob_valid_second_o,

    // exception control
    input  logic                    global_trap_i,
    input  logic                    global_predict_miss_i,
    input  logic                    global_ret_i,
    input  logic                    global_wfi_i,

    // plic and clint
    input  logic                    eip_i,
    input  logic                    stip_i,
    input  logic                    mtip_i,
    input  logic                    ssip_i,
    input  logic                    msip_i
);

    decode_pkg::dec_entry_t dec_first;
    decode_pkg::dec_entry_t dec_second;
    decode_pkg::dec_entry_t irq_first;
    decode_pkg::dec_entry_t irq_second;
    logic                   flush;
    logic                   single_space;
    logic                   double_space;

    assign flush = global_trap_i | global_predict_miss_i | global_ret_i;

    // wfi holds fetch off, writes still go through
    assign fetch_single_ready_o = single_space & ~global_wfi_i;
    assign fetch_double_ready_o = double_space & ~global_wfi_i;

    inst_decoder decoder_first (
        .slot_i  (fetch_slot_first_i),
        .entry_o (dec_first)
    );

    inst_decoder decoder_second (
        .slot_i  (fetch_slot_second_i),
        .entry_o (dec_second)
    );

    irq_override irq_override_inst (
        .entry_first_i  (dec_first),
        .entry_second_i (dec_second),
        .eip_i          (eip_i),
        .stip_i         (stip_i),
        .mtip_i         (mtip_i),
        .ssip_i         (ssip_i),
        .msip_i         (msip_i),
        .entry_first_o  (irq_first),
        .entry_second_o (irq_second)
    );

    dual_queue #(
        .entry_t (decode_pkg::dec_entry_t)
    ) queue_inst (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush),
        .wr_valid_first_i  (fetch_valid_first_i),
        .wr_valid_second_i (fetch_valid_second_i),
        .rd_ready_first_i  (rob_ready_first_i),
        .rd_ready_second_i (rob_ready_second_i),
        .wdata_first_i     (irq_first),
        .wdata_second_i    (irq_second),
        .rdata_first_o     (entry_first_o),
        .rdata_second_o    (entry_second_o),
        .rd_valid_first_o  (rob_valid_first_o),
        .rd_valid_second_o (rob_valid_second_o),
        .single_space_o    (single_space),
        .double_space_o    (double_space)
    );

endmodule

/* tb/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int DEC_ROWS    = 13;
    localparam int IRQ_ROWS    = 6;
    localparam int WATCHDOG_NS = (DEC_ROWS + IRQ_ROWS) * 20 * CLK_PERIOD;
    localparam logic [31:0] ADDI_WORD = 32'hffb1_0093; // addi x1, x2, -5
    localparam logic [31:0] SUB_WORD  = 32'h4052_01b3; // sub x3, x4, x5

    typedef struct packed {
        logic [31:0] inst;
        logic        fetch_exc;
        logic [4:0]  fetch_cause;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  uses;     // rs1 rs2 rd
        logic [31:0] imm;
        logic [2:0]  fu;
        logic        modifier;
        logic [1:0]  sel_a;
        logic [1:0]  sel_b;
        logic [4:0]  kind;     // alu load store branch jump
        logic        exc;
        logic [4:0]  cause;
    } dec_row_t;

    typedef struct packed {
        logic [4:0] lines;     // eip stip mtip ssip msip
        logic [4:0] cause;
    } irq_row_t;

    logic                    clk;
    logic                    rst_n_i;
    decode_pkg::fetch_slot_t fetch_slot_first_i;
    decode_pkg::fetch_slot_t fetch_slot_second_i;
    logic                    fetch_valid_first_i;
    logic                    fetch_valid_second_i;
    logic                    fetch_single_ready_o;
    logic                    fetch_double_ready_o;
    logic                    rob_ready_first_i;
    logic                    rob_ready_second_i;
    decode_pkg::dec_entry_t  entry_first_o;
    decode_pkg::dec_entry_t  entry_second_o;
    logic                    rob_valid_first_o;
    logic                    rob_valid_second_o;
    logic                    global_trap_i;
    logic                    global_predict_miss_i;
    logic                    global_ret_i;
    logic                    global_wfi_i;
    logic                    eip_i;
    logic                    stip_i;
    logic                    mtip_i;
    logic                    ssip_i;
    logic                    msip_i;

    dec_row_t    dec_rows [DEC_ROWS];
    irq_row_t    irq_rows [IRQ_ROWS];
    logic [31:0] pc_q [$];
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          test_start_errors;

    decode_stage decode_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic load_tables();
        dec_rows[0]  = '{ADDI_WORD, 1'b0, 5'd0, 5'd2, 5'd27, 5'd1, 3'b101,
                         32'hffff_fffb, 3'd0, 1'b0, 2'd0, 2'd1, 5'b10000, 1'b0, 5'd0};
        dec_rows[1]  = '{SUB_WORD, 1'b0, 5'd0, 5'd4, 5'd5, 5'd3, 3'b111,
                         32'h0000_0000, 3'd0, 1'b1, 2'd0, 2'd0, 5'b10000, 1'b0, 5'd0};
        dec_rows[2]  = '{32'h4033_d313, 1'b0, 5'd0, 5'd7, 5'd3, 5'd6, 3'b101,
                         32'h0000_0403, 3'd5, 1'b1, 2'd0, 2'd1, 5'b10000, 1'b0, 5'd0}; // srai
        dec_rows[3]  = '{32'h1234_5537, 1'b0, 5'd0, 5'd8, 5'd3, 5'd10, 3'b001,
                         32'h1234_5000, 3'd0, 1'b0, 2'd2, 2'd1, 5'b10000, 1'b0, 5'd0}; // lui
        dec_rows[4]  = '{32'hffff_f297, 1'b0, 5'd0, 5'd31, 5'd31, 5'd5, 3'b001,
                         32'hffff_f000, 3'd0, 1'b0, 2'd1, 2'd1, 5'b10000, 1'b0, 5'd0};
        dec_rows[5]  = '{32'h0080_00ef, 1'b0, 5'd0, 5'd0, 5'd8, 5'd1, 3'b001,
                         32'h0000_0008, 3'd0, 1'b0, 2'd1, 2'd2, 5'b00001, 1'b0, 5'd0}; // jal
        dec_rows[6]  = '{32'h0000_8067, 1'b0, 5'd0, 5'd1, 5'd0, 5'd0, 3'b101,
                         32'h0000_0000, 3'd0, 1'b0, 2'd1, 2'd2, 5'b00001, 1'b0, 5'd0};
        dec_rows[7]  = '{32'hfe20_8ee3, 1'b0, 5'd0, 5'd1, 5'd2, 5'd29, 3'b110,
                         32'hffff_fffc, 3'd0, 1'b0, 2'd0, 2'd0, 5'b00010, 1'b0, 5'd0}; // beq
        dec_rows[8]  = '{32'h00c4_a403, 1'b0, 5'd0, 5'd9, 5'd12, 5'd8, 3'b101,
                         32'h0000_000c, 3'd2, 1'b0, 2'd0, 2'd1, 5'b01000, 1'b0, 5'd0}; // lw
        dec_rows[9]  = '{32'hfe53_2c23, 1'b0, 5'd0, 5'd6, 5'd5, 5'd24, 3'b110,
                         32'hffff_fff8, 3'd2, 1'b0, 2'd0, 2'd1, 5'b00100, 1'b0, 5'd0}; // sw
        // custom opcode, then a fetch fault, then low bits 00
        dec_rows[10] = '{32'h0000_007b, 1'b0, 5'd0, 5'd0, 5'd0, 5'd0, 3'b000,
                         32'h0000_0000, 3'd0, 1'b0, 2'd0, 2'd0, 5'b00000, 1'b1, 5'd2};
        dec_rows[11] = '{32'h0000_0000, 1'b1, 5'd1, 5'd0, 5'd0, 5'd0, 3'b000,
                         32'h0000_0000, 3'd0, 1'b0, 2'd0, 2'd0, 5'b00000, 1'b1, 5'd1};
        dec_rows[12] = '{32'h0000_0010, 1'b0, 5'd0, 5'd0, 5'd0, 5'd0, 3'b000,
                         32'h0000_0000, 3'd0, 1'b0, 2'd0, 2'd0, 5'b00000, 1'b1, 5'd2};
        irq_rows[0] = '{5'b10000, 5'h19};
        irq_rows[1] = '{5'b01111, 5'h15};
        irq_rows[2] = '{5'b00111, 5'h17};
        irq_rows[3] = '{5'b00011, 5'h11};
        irq_rows[4] = '{5'b00001, 5'h13};
        irq_rows[5] = '{5'b11111, 5'h19};  // everything pending
    endtask

    task automatic drive_idle();
        fetch_slot_first_i    = '0;
        fetch_slot_second_i   = '0;
        fetch_valid_first_i   = 1'b0;
        fetch_valid_second_i  = 1'b0;
        rob_ready_first_i     = 1'b0;
        rob_ready_second_i    = 1'b0;
        global_trap_i         = 1'b0;
        global_predict_miss_i = 1'b0;
        global_ret_i          = 1'b0;
        global_wfi_i          = 1'b0;
        {eip_i, stip_i, mtip_i, ssip_i, msip_i} = 5'b00000;
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic decode_pkg::fetch_slot_t make_slot(input logic [31:0] inst,
                                                          input logic        fault,
                                                          input logic [4:0]  cause,
                                                          input logic [31:0] pc);
        decode_pkg::fetch_slot_t s;
        s.pc           = pc;
        s.next_pc      = pc + 32'd4;
        s.predicted_pc = $urandom;
        s.instruction  = inst;
        s.exception    = fault;
        s.ecause       = cause;
        return s;
    endfunction

    function automatic decode_pkg::dec_entry_t expected_entry(input dec_row_t row,
                                                              input decode_pkg::fetch_slot_t s);
        decode_pkg::dec_entry_t e;
        e.pc           = s.pc;
        e.next_pc      = s.next_pc;
        e.predicted_pc = s.predicted_pc;
        e.rs1          = row.rs1;
        e.rs2          = row.rs2;
        e.rd           = row.rd;
        {e.uses_rs1, e.uses_rs2, e.uses_rd} = row.uses;
        e.imm          = row.imm;
        e.fu_function  = row.fu;
        e.alu_modifier = row.modifier;
        e.select_a     = row.sel_a;
        e.select_b     = row.sel_b;
        {e.is_alu, e.load, e.store, e.branch, e.jump} = row.kind;
        e.exception    = row.exc;
        e.ecause       = row.cause;
        return e;
    endfunction

    task automatic check_entry(input string name, input decode_pkg::dec_entry_t exp_e,
                               input decode_pkg::dec_entry_t act_e);
        if (act_e !== exp_e) begin
            $display("FAILED %s: expected %h, actual %h", name, exp_e, act_e);
            error_count++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_b, input logic act_b);
        if (act_b !== exp_b) begin
            $display("FAILED %s: expected %b, actual %b", name, exp_b, act_b);
            error_count++;
        end
    endtask

    task automatic start_test();
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count != test_start_errors) begin
            failed_tests++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // holds the slots for one edge
    task automatic offer(input decode_pkg::fetch_slot_t first_s,
                         input decode_pkg::fetch_slot_t second_s,
                         input logic v1, input logic v2);
        fetch_slot_first_i   = first_s;
        fetch_slot_second_i  = second_s;
        fetch_valid_first_i  = v1;
        fetch_valid_second_i = v2;
        tick();
        fetch_valid_first_i  = 1'b0;
        fetch_valid_second_i = 1'b0;
    endtask

    task automatic pop_entries(input logic r1, input logic r2);
        rob_ready_first_i  = r1;
        rob_ready_second_i = r2;
        tick();
        rob_ready_first_i  = 1'b0;
        rob_ready_second_i = 1'b0;
    endtask

    task automatic run_decode_rows();
        decode_pkg::fetch_slot_t s;
        for (int i = 0; i < DEC_ROWS; i++) begin
            start_test();
            s = make_slot(dec_rows[i].inst, dec_rows[i].fetch_exc, dec_rows[i].fetch_cause,
                          $urandom & 32'hffff_fffc);
            offer(s, s, 1'b1, 1'b0);
            check_bit($sformatf("decode row %0d valid", i), 1'b1, rob_valid_first_o);
            check_entry($sformatf("decode row %0d entry", i), expected_entry(dec_rows[i], s),
                        entry_first_o);
            pop_entries(1'b1, 1'b0);
            end_test($sformatf("decode row %0d", i));
        end
    endtask

    task automatic run_dual_issue();
        decode_pkg::fetch_slot_t older;
        decode_pkg::fetch_slot_t younger;
        start_test();
        older   = make_slot(ADDI_WORD, 1'b0, 5'd0, 32'h0000_1000);
        younger = make_slot(SUB_WORD, 1'b0, 5'd0, 32'h0000_1004);
        offer(older, younger, 1'b1, 1'b1);
        check_bit("dual issue valid first", 1'b1, rob_valid_first_o);
        check_bit("dual issue valid second", 1'b1, rob_valid_second_o);
        check_value("dual issue first pc", older.pc, entry_first_o.pc);
        check_value("dual issue second pc", younger.pc, entry_second_o.pc);
        pop_entries(1'b1, 1'b1);
        check_bit("dual issue empty after pop", 1'b0, rob_valid_first_o);
        end_test("dual issue order");
    endtask

    task automatic run_back_pressure();
        decode_pkg::fetch_slot_t first_s;
        decode_pkg::fetch_slot_t second_s;
        logic [31:0]             pc;
        int                      drained;
        start_test();
        pc = 32'h0000_2000;
        pc_q.delete();
        for (int p = 0; p < 3; p++) begin
            check_bit($sformatf("double ready at %0d entries", 2 * p), 1'b1,
                      fetch_double_ready_o);
            first_s  = make_slot(ADDI_WORD, 1'b0, 5'd0, pc);
            second_s = make_slot(ADDI_WORD, 1'b0, 5'd0, pc + 32'd4);
            pc_q.push_back(pc);
            pc_q.push_back(pc + 32'd4);
            offer(first_s, second_s, 1'b1, 1'b1);
            pc = pc + 32'd8;
        end
        check_bit("double ready at 6 entries", 1'b1, fetch_double_ready_o);
        first_s = make_slot(ADDI_WORD, 1'b0, 5'd0, pc);
        pc_q.push_back(pc);
        offer(first_s, first_s, 1'b1, 1'b0);
        pc = pc + 32'd4;
        check_bit("double ready at 7 entries", 1'b0, fetch_double_ready_o);
        check_bit("single ready at 7 entries", 1'b1, fetch_single_ready_o);
        // only the older slot fits
        first_s  = make_slot(ADDI_WORD, 1'b0, 5'd0, pc);
        second_s = make_slot(ADDI_WORD, 1'b0, 5'd0, pc + 32'd4);
        pc_q.push_back(pc);
        offer(first_s, second_s, 1'b1, 1'b1);
        check_bit("single ready at 8 entries", 1'b0, fetch_single_ready_o);
        drained = 0;
        while (rob_valid_first_o && pc_q.size() > 0) begin
            check_value("drain order", pc_q.pop_front(), entry_first_o.pc);
            drained++;
            pop_entries(1'b1, 1'b0);
        end
        check_value("drained entries", 32'd8, drained);
        check_bit("queue empty after drain", 1'b0, rob_valid_first_o);
        end_test("back-pressure");
    endtask

    task automatic run_irq_rows();
        decode_pkg::fetch_slot_t first_s;
        decode_pkg::fetch_slot_t second_s;
        for (int i = 0; i < IRQ_ROWS; i++) begin
            start_test();
            first_s  = make_slot(ADDI_WORD, 1'b0, 5'd0, $urandom & 32'hffff_fffc);
            second_s = make_slot(SUB_WORD, 1'b0, 5'd0, $urandom & 32'hffff_fffc);
            {eip_i, stip_i, mtip_i, ssip_i, msip_i} = irq_rows[i].lines;
            offer(first_s, second_s, 1'b1, 1'b1);
            {eip_i, stip_i, mtip_i, ssip_i, msip_i} = 5'b00000;
            check_bit($sformatf("irq row %0d first exception", i), 1'b1, entry_first_o.exception);
            check_bit($sformatf("irq row %0d second exception", i), 1'b1,
                      entry_second_o.exception);
            check_value($sformatf("irq row %0d first cause", i), {27'd0, irq_rows[i].cause},
                        {27'd0, entry_first_o.ecause});
            check_value($sformatf("irq row %0d second cause", i), {27'd0, irq_rows[i].cause},
                        {27'd0, entry_second_o.ecause});
            pop_entries(1'b1, 1'b1);
            end_test($sformatf("irq row %0d", i));
        end
    endtask

    task automatic run_flush();
        decode_pkg::fetch_slot_t s;
        for (int src = 0; src < 3; src++) begin
            start_test();
            s = make_slot(ADDI_WORD, 1'b0, 5'd0, 32'h0000_3000);
            offer(s, s, 1'b1, 1'b1);
            check_bit("flush setup valid", 1'b1, rob_valid_second_o);
            global_trap_i         = (src == 0);
            global_predict_miss_i = (src == 1);
            global_ret_i          = (src == 2);
            offer(s, s, 1'b1, 1'b0); // dropped, flush wins
            global_trap_i         = 1'b0;
            global_predict_miss_i = 1'b0;
            global_ret_i          = 1'b0;
            check_bit("first valid after flush", 1'b0, rob_valid_first_o);
            check_bit("second valid after flush", 1'b0, rob_valid_second_o);
            end_test($sformatf("flush source %0d", src));
        end
    endtask

    task automatic run_wfi();
        start_test();
        global_wfi_i = 1'b1;
        tick();
        check_bit("single ready under wfi", 1'b0, fetch_single_ready_o);
        check_bit("double ready under wfi", 1'b0, fetch_double_ready_o);
        global_wfi_i = 1'b0;
        tick();
        check_bit("single ready after wfi", 1'b1, fetch_single_ready_o);
        check_bit("double ready after wfi", 1'b1, fetch_double_ready_o);
        end_test("wfi hold");
    endtask

    initial begin
        void'($urandom(32'h9b5c_6989));
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        rst_n_i      = 1'b0;
        drive_idle();
        load_tables();
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        start_test();
        check_bit("reset valid first", 1'b0, rob_valid_first_o);
        check_bit("reset valid second", 1'b0, rob_valid_second_o);
        check_bit("reset single ready", 1'b1, fetch_single_ready_o);
        check_bit("reset double ready", 1'b1, fetch_double_ready_o);
        end_test("reset state");

        run_decode_rows();
        run_dual_issue();
        run_back_pressure();
        run_irq_rows();
        run_flush();
        run_wfi();

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/irq_override.sv
hdl/dual_queue.sv
hdl/decode_stage.sv
tb/decode_tb.sv

/* run.sh */
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module decode_tb \
    -f compile.f

./obj_dir/Vdecode_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
